// File: hw/mem_ctrl_cfg.svh
// widths of the byte-serial memory controller; the extension logic assumes 32-bit words
// over an 8-bit bus
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// client address and word
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// external RAM data bus, one byte per bus cycle
`define MEM_BUS_W 8

// I/O space when both bits are set (0x30000 and up)
`define MEM_IO_HI 17
`define MEM_IO_LO 16

`endif

// File: hw/mem_ctrl_pkg.sv
// request and grant types shared by the memory controller blocks
`default_nettype none

`include "mem_ctrl_cfg.svh"

package mem_ctrl_pkg;

    // byte count minus one is derived from these codes
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    // data port request, stable while req is high
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        mem_size_e              size;
        logic                   sign;
        logic                   write;
        logic [`MEM_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_IF   = 2'd1,
        GRANT_D    = 2'd2
    } grant_e;

endpackage

`default_nettype wire

// File: hw/mem_arbiter_fsm.sv
// data port wins over fetch; both use a four-phase req/ack handshake
// the I/O decode looks at the base address only, so an access must not cross into I/O space
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_arbiter_fsm (
    input  wire                         clk_in,
    input  wire                         rst_n_i,
    input  wire                         en_i,
    input  wire                         if_req_i,
    input  wire [`MEM_ADDR_W-1:0]       if_addr_i,
    input  wire                         d_req_i,
    input  wire mem_ctrl_pkg::mem_req_t d_cmd_i,
    input  wire                         last_i,
    input  wire                         io_full_i,
    output mem_ctrl_pkg::grant_e        grant_o,
    output mem_ctrl_pkg::mem_req_t      sel_o,
    output logic                        cnt_load_o,
    output logic                        cnt_step_o,
    output logic                        issue_o,
    output logic                        cap_o,
    output logic                        if_ack_o,
    output logic                        d_ack_o
);

    typedef enum logic [1:0] {IDLE, ISSUE, DRAIN, ACK} state_e;

    state_e                 state_q;
    mem_ctrl_pkg::grant_e   grant_q;
    mem_ctrl_pkg::mem_req_t sel_q;
    logic                   cap_q;
    logic                   if_ack_q;
    logic                   d_ack_q;
    logic                   io_hold;
    logic                   owner_req;

    // write byte to a full I/O buffer waits in place
    assign io_hold = sel_q.write & sel_q.addr[`MEM_IO_HI] & sel_q.addr[`MEM_IO_LO] & io_full_i;
    assign owner_req = (grant_q == mem_ctrl_pkg::GRANT_D) ? d_req_i : if_req_i;

    assign issue_o    = (state_q == ISSUE) & ~io_hold;
    assign cnt_load_o = (state_q == IDLE);
    assign cnt_step_o = issue_o & ~last_i;
    assign cap_o      = cap_q;
    assign grant_o    = grant_q;
    assign sel_o      = sel_q;
    assign if_ack_o   = if_ack_q;
    assign d_ack_o    = d_ack_q;

    always_ff @(posedge clk_in) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            grant_q  <= mem_ctrl_pkg::GRANT_NONE;
            cap_q    <= 1'b0;
            if_ack_q <= 1'b0;
            d_ack_q  <= 1'b0;
        end else if (en_i) begin
            // read byte arrives one cycle after its address
            cap_q <= issue_o & ~sel_q.write;
            case (state_q)
                IDLE: begin
                    if (d_req_i) begin
                        grant_q <= mem_ctrl_pkg::GRANT_D;
                        state_q <= ISSUE;
                    end else if (if_req_i) begin
                        grant_q <= mem_ctrl_pkg::GRANT_IF;
                        state_q <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (issue_o && last_i) begin
                        state_q <= sel_q.write ? ACK : DRAIN;
                    end
                end
                DRAIN: state_q <= ACK;
                ACK: begin
                    if (grant_q == mem_ctrl_pkg::GRANT_D) begin
                        d_ack_q <= d_req_i;
                    end else begin
                        if_ack_q <= if_req_i;
                    end
                    if (!owner_req) begin
                        state_q <= IDLE;
                        grant_q <= mem_ctrl_pkg::GRANT_NONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // fetch becomes an unsigned word read
    always_ff @(posedge clk_in) begin
        if (en_i && state_q == IDLE) begin
            if (d_req_i) begin
                sel_q <= d_cmd_i;
            end else if (if_req_i) begin
                sel_q.addr  <= if_addr_i;
                sel_q.size  <= mem_ctrl_pkg::SIZE_W;
                sel_q.sign  <= 1'b0;
                sel_q.write <= 1'b0;
                sel_q.wdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/byte_counter.sv
// byte index of the current access; while paused it shows the previous step again
`default_nettype none

module byte_counter (
    input  wire                          clk_in,
    input  wire                          rst_n_i,
    input  wire                          en_i,
    input  wire                          load_i,
    input  wire                          step_i,
    input  wire mem_ctrl_pkg::mem_size_e size_i,
    output logic [1:0]                   idx_o,
    output logic                         last_o
);

    logic [1:0] idx_q;
    logic [1:0] prev_q;
    logic [1:0] top;

    // N-1: byte 0, half 1, word 3
    assign top    = {size_i[1], size_i[1] | size_i[0]};
    assign last_o = (idx_q == top);

    // paused RAM keeps re-reading the byte the assembler still owes a capture
    assign idx_o = en_i ? idx_q : prev_q;

    always_ff @(posedge clk_in) begin
        if (!rst_n_i) begin
            idx_q  <= 2'd0;
            prev_q <= 2'd0;
        end else if (en_i) begin
            prev_q <= idx_q;
            if (load_i) begin
                idx_q <= 2'd0;
            end else if (step_i) begin
                idx_q <= idx_q + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/read_assembler.sv
// little-endian byte capture; the word output is only updated by the top byte of an access
`default_nettype none

`include "mem_ctrl_cfg.svh"

module read_assembler (
    input  wire                          clk_in,
    input  wire                          rst_n_i,
    input  wire                          en_i,
    input  wire                          cap_i,
    input  wire [1:0]                    idx_i,
    input  wire mem_ctrl_pkg::mem_size_e size_i,
    input  wire                          sign_i,
    input  wire [`MEM_BUS_W-1:0]         byte_i,
    output logic [`MEM_DATA_W-1:0]       word_o
);

    logic [1:0]             idx_d;
    logic [1:0]             top;
    logic [`MEM_DATA_W-1:0] buf_q;
    logic [`MEM_DATA_W-1:0] word_q;
    logic [`MEM_DATA_W-1:0] merged;
    logic [`MEM_DATA_W-1:0] ext;

    assign top    = {size_i[1], size_i[1] | size_i[0]};
    assign word_o = word_q;

    always_comb begin
        merged = buf_q;
        merged[idx_d*`MEM_BUS_W +: `MEM_BUS_W] = byte_i;
    end

    always_comb begin
        case (size_i)
            mem_ctrl_pkg::SIZE_B: ext = {{(`MEM_DATA_W-`MEM_BUS_W){sign_i & merged[`MEM_BUS_W-1]}},
                                         merged[`MEM_BUS_W-1:0]};
            mem_ctrl_pkg::SIZE_H: ext = {{(`MEM_DATA_W-2*`MEM_BUS_W){sign_i & merged[2*`MEM_BUS_W-1]}},
                                         merged[2*`MEM_BUS_W-1:0]};
            default:              ext = merged;
        endcase
    end

    // lane of the byte now on the bus, one cycle behind the issue
    always_ff @(posedge clk_in) begin
        if (!rst_n_i) begin
            idx_d <= 2'd0;
        end else if (en_i) begin
            idx_d <= idx_i;
        end
    end

    always_ff @(posedge clk_in) begin
        if (en_i && cap_i) begin
            buf_q <= merged;
            if (idx_d == top) begin
                word_q <= ext;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/ram_bus_driver.sv
// combinational drive of the 8-bit RAM bus for the current byte step
`default_nettype none

`include "mem_ctrl_cfg.svh"

module ram_bus_driver (
    input  wire                         en_i,
    input  wire                         issue_i,
    input  wire mem_ctrl_pkg::mem_req_t req_i,
    input  wire [1:0]                   idx_i,
    output logic [`MEM_ADDR_W-1:0]      mem_a_o,
    output logic [`MEM_BUS_W-1:0]       mem_dout_o,
    output logic                        mem_wr_o
);

    // byte address walks up from the request address
    assign mem_a_o = req_i.addr + `MEM_ADDR_W'(idx_i);

    // little-endian lane of the write data
    assign mem_dout_o = req_i.wdata[idx_i*`MEM_BUS_W +: `MEM_BUS_W];

    // no strobe while paused or while an I/O byte waits
    assign mem_wr_o = en_i & issue_i & req_i.write;

endmodule

`default_nettype wire

// File: hw/mem_ctrl.sv
// byte-serial RAM controller for fetch and data clients; rdy_i low pauses everything
// read data on either port is valid only while that port's ack is high
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_ctrl (
    input  wire                         clk_in,
    input  wire                         rst_n_i,
    input  wire                         rdy_i,
    input  wire [`MEM_BUS_W-1:0]        mem_din_i,
    output logic [`MEM_BUS_W-1:0]       mem_dout_o,
    output logic [`MEM_ADDR_W-1:0]      mem_a_o,
    output logic                        mem_wr_o,
    input  wire                         io_buffer_full_i,
    input  wire                         if_req_i,
    input  wire [`MEM_ADDR_W-1:0]       if_addr_i,
    output logic                        if_ack_o,
    output logic [`MEM_DATA_W-1:0]      if_rdata_o,
    input  wire                         d_req_i,
    input  wire mem_ctrl_pkg::mem_req_t d_cmd_i,
    output logic                        d_ack_o,
    output logic [`MEM_DATA_W-1:0]      d_rdata_o
);

    mem_ctrl_pkg::mem_req_t sel;
    logic                   cnt_load;
    logic                   cnt_step;
    logic                   issue;
    logic                   cap;
    logic                   last;
    logic [1:0]             idx;
    logic [`MEM_DATA_W-1:0] word;

    mem_arbiter_fsm u_fsm (
        .clk_in     (clk_in),
        .rst_n_i    (rst_n_i),
        .en_i       (rdy_i),
        .if_req_i   (if_req_i),
        .if_addr_i  (if_addr_i),
        .d_req_i    (d_req_i),
        .d_cmd_i    (d_cmd_i),
        .last_i     (last),
        .io_full_i  (io_buffer_full_i),
        .grant_o    (),
        .sel_o      (sel),
        .cnt_load_o (cnt_load),
        .cnt_step_o (cnt_step),
        .issue_o    (issue),
        .cap_o      (cap),
        .if_ack_o   (if_ack_o),
        .d_ack_o    (d_ack_o)
    );

    byte_counter u_cnt (
        .clk_in  (clk_in),
        .rst_n_i (rst_n_i),
        .en_i    (rdy_i),
        .load_i  (cnt_load),
        .step_i  (cnt_step),
        .size_i  (sel.size),
        .idx_o   (idx),
        .last_o  (last)
    );

    read_assembler u_rasm (
        .clk_in  (clk_in),
        .rst_n_i (rst_n_i),
        .en_i    (rdy_i),
        .cap_i   (cap),
        .idx_i   (idx),
        .size_i  (sel.size),
        .sign_i  (sel.sign),
        .byte_i  (mem_din_i),
        .word_o  (word)
    );

    ram_bus_driver u_bus (
        .en_i       (rdy_i),
        .issue_i    (issue),
        .req_i      (sel),
        .idx_i      (idx),
        .mem_a_o    (mem_a_o),
        .mem_dout_o (mem_dout_o),
        .mem_wr_o   (mem_wr_o)
    );

    assign if_rdata_o = word;
    assign d_rdata_o  = word;

endmodule

`default_nettype wire

// File: sim/mem_ctrl_chk.sv
// port protocol assertions, bound into every mem_ctrl instance
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_ctrl_chk (
    input wire                   clk_in,
    input wire                   rst_n_i,
    input wire                   rdy_i,
    input wire                   io_full_i,
    input wire [`MEM_ADDR_W-1:0] mem_a_i,
    input wire                   mem_wr_i,
    input wire                   if_ack_i,
    input wire                   d_ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    a_reset_idle: assert property (@(posedge clk_in)
        !rst_n_i |=> !if_ack_i && !d_ack_i && !mem_wr_i)
        else $error("ack or write strobe high right after reset");

    a_one_ack: assert property (@(posedge clk_in) disable iff (!rst_n_i)
        !(if_ack_i && d_ack_i))
        else $error("fetch and data acks high together");

    a_no_write_paused: assert property (@(posedge clk_in) disable iff (!rst_n_i)
        !rdy_i |-> !mem_wr_i)
        else $error("write strobe while rdy is low");

    // full I/O buffer blocks bytes into I/O space
    a_no_write_io_full: assert property (@(posedge clk_in) disable iff (!rst_n_i)
        (io_full_i && mem_a_i[`MEM_IO_HI] && mem_a_i[`MEM_IO_LO]) |-> !mem_wr_i)
        else $error("I/O write while the I/O buffer is full");

endmodule

bind mem_ctrl mem_ctrl_chk u_chk (
    .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_i(rdy_i), .io_full_i(io_buffer_full_i),
    .mem_a_i(mem_a_o), .mem_wr_i(mem_wr_o), .if_ack_i(if_ack_o), .d_ack_i(d_ack_o)
);

`default_nettype wire

// File: sim/mem_ctrl_tb.sv
// directed tests for mem_ctrl against a 128 KB byte RAM model with one cycle of read latency
// writes at 0x30000 and up go to an I/O log, so test accesses never cross that boundary
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   rdy = 1'b1;
    logic                   io_full = 1'b0;
    logic                   if_req = 1'b0;
    logic                   d_req = 1'b0;
    logic                   pause_on = 1'b0;
    logic                   wr_s = 1'b0;
    logic [`MEM_ADDR_W-1:0] if_addr = '0;
    mem_ctrl_pkg::mem_req_t d_cmd = '0;
    logic [`MEM_BUS_W-1:0]  mem_din = '0;
    logic [`MEM_BUS_W-1:0]  mem_dout, dout_s;
    logic [`MEM_ADDR_W-1:0] mem_a, a_s;
    logic [`MEM_DATA_W-1:0] if_rdata, d_rdata;
    logic                   mem_wr, if_ack, d_ack;
    logic [7:0]             ram [0:131071];
    logic [7:0]             io_log [$];
    integer                 seed = 4458;

    mem_ctrl u_mem_ctrl (
        .clk_in(clk), .rst_n_i(rst_n), .rdy_i(rdy), .mem_din_i(mem_din),
        .mem_dout_o(mem_dout), .mem_a_o(mem_a), .mem_wr_o(mem_wr),
        .io_buffer_full_i(io_full), .if_req_i(if_req), .if_addr_i(if_addr),
        .if_ack_o(if_ack), .if_rdata_o(if_rdata), .d_req_i(d_req), .d_cmd_i(d_cmd),
        .d_ack_o(d_ack), .d_rdata_o(d_rdata)
    );

    always #20 clk = ~clk;

    // bus sampled mid-cycle, served at the next edge
    always @(negedge clk) begin
        a_s    <= mem_a;
        wr_s   <= mem_wr;
        dout_s <= mem_dout;
    end

    always @(posedge clk) begin
        mem_din <= ram[a_s[16:0]];
        if (wr_s && a_s[`MEM_IO_HI] && a_s[`MEM_IO_LO]) begin
            io_log.push_back(dout_s);
        end else if (wr_s) begin
            ram[a_s[16:0]] = dout_s;
        end
    end

    // random rdy gaps while pausing is on
    always begin
        next_cycle();
        rdy = !pause_on || (($random(seed) & 3) != 0);
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic wait_ack(input logic data_port, input logic level);
        int n;
        for (n = 0; (data_port ? d_ack : if_ack) != level; n++) begin
            if (n == 300) begin
                fail_run($sformatf("timeout: the %s ack never went to %0b",
                                   data_port ? "data" : "fetch", level));
            end
            next_cycle();
        end
    endtask

    task automatic data_access(input logic [31:0] addr, input mem_ctrl_pkg::mem_size_e size,
                               input logic sign, input logic wr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        d_cmd = '{addr, size, sign, wr, wdata};
        d_req = 1'b1;
        wait_ack(1'b1, 1'b1);
        rdata = d_rdata;
        d_req = 1'b0;
        wait_ack(1'b1, 1'b0);
    endtask

    // n RAM bytes little-endian, extended from byte n-1 when signed
    function automatic logic [31:0] ram_value(input logic [31:0] addr, input int n,
                                              input logic sign);
        logic [31:0] w;
        int k;
        w = '0;
        for (k = 0; k < n; k++) begin
            w[8*k +: 8] = ram[addr[16:0] + 17'(k)];
        end
        if (sign && n < 4 && w[8*n-1]) begin
            w = w | (32'hffff_ffff << (8 * n));
        end
        return w;
    endfunction

    function automatic logic [31:0] rand_addr();
        return 32'h0000_1000 + ($random(seed) & 32'h0001_dfff);
    endfunction

    task automatic test_fetch();
        logic [31:0] a;
        repeat (4) begin
            a = rand_addr() & ~32'h3;
            if_addr = a;
            if_req = 1'b1;
            wait_ack(1'b0, 1'b1);
            check_eq("fetch", ram_value(a, 4, 1'b0), if_rdata);
            if_req = 1'b0;
            wait_ack(1'b0, 1'b0);
        end
    endtask

    task automatic test_reads(input string name);
        logic [31:0] a;
        logic [31:0] got;
        int i;
        int n;
        for (i = 0; i < 12; i++) begin
            a = rand_addr();
            n = 1 << ((i >> 1) % 3);
            // top byte sign bit clear in the first half, set in the second
            ram[a[16:0] + 17'(n - 1)][7] = (i >= 6);
            data_access(a, mem_ctrl_pkg::mem_size_e'(2'((i >> 1) % 3)), 1'(i % 2), 1'b0, '0, got);
            check_eq(name, ram_value(a, n, 1'(i % 2)), got);
        end
    endtask

    task automatic test_writes(input string name);
        logic [31:0] a, wd, old, keep, got;
        logic [7:0]  below, above;
        int i;
        for (i = 0; i < 6; i++) begin
            a = rand_addr();
            wd = $random(seed);
            old = ram_value(a, 4, 1'b0);
            below = ram[a[16:0] - 17'd1];
            above = ram[a[16:0] + 17'd4];
            // lanes from N up keep their old bytes
            keep = 32'hffff_ffff << (8 << (i % 3));
            data_access(a, mem_ctrl_pkg::mem_size_e'(2'(i % 3)), 1'b0, 1'b1, wd, got);
            data_access(a, mem_ctrl_pkg::SIZE_W, 1'b0, 1'b0, '0, got);
            check_eq(name, (old & keep) | (wd & ~keep), got);
            check_eq({name, " below"}, 32'(below), 32'(ram[a[16:0] - 17'd1]));
            check_eq({name, " above"}, 32'(above), 32'(ram[a[16:0] + 17'd4]));
        end
    endtask

    task automatic test_same_cycle();
        logic [31:0] a;
        logic [31:0] b;
        a = rand_addr() & ~32'h3;
        b = rand_addr();
        if_addr = a;
        d_cmd = '{b, mem_ctrl_pkg::SIZE_W, 1'b0, 1'b0, 32'd0};
        if_req = 1'b1;
        d_req = 1'b1;
        wait_ack(1'b1, 1'b1);
        check_eq("priority fetch ack", 32'd0, 32'(if_ack));
        check_eq("priority data", ram_value(b, 4, 1'b0), d_rdata);
        d_req = 1'b0;
        wait_ack(1'b1, 1'b0);
        wait_ack(1'b0, 1'b1);
        check_eq("priority fetch", ram_value(a, 4, 1'b0), if_rdata);
        if_req = 1'b0;
        wait_ack(1'b0, 1'b0);
    endtask

    task automatic test_io_write();
        logic [31:0] wd;
        int base, hold, k;
        base = io_log.size();
        wd = $random(seed);
        hold = 4 + ($random(seed) & 15);
        io_full = 1'b1;
        d_cmd = '{32'h0003_0040, mem_ctrl_pkg::SIZE_W, 1'b0, 1'b1, wd};
        d_req = 1'b1;
        repeat (hold) begin
            next_cycle();
            check_eq("io held", 32'(base), 32'(io_log.size()));
        end
        io_full = 1'b0;
        wait_ack(1'b1, 1'b1);
        d_req = 1'b0;
        wait_ack(1'b1, 1'b0);
        check_eq("io count", 32'(base + 4), 32'(io_log.size()));
        for (k = 0; k < 4; k++) begin
            check_eq("io byte", 32'(wd[8*k +: 8]), 32'(io_log[base + k]));
        end
    endtask

    initial begin
        int i;
        // pattern mixes every address bit
        for (i = 0; i < 131072; i++) begin
            ram[17'(i)] = 8'(i * 29) ^ 8'(i >> 8) ^ 8'(i >> 16);
        end
        repeat (8) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        test_fetch();
        test_reads("read");
        test_writes("write");
        test_same_cycle();
        test_io_write();
        pause_on = 1'b1;
        test_reads("paused read");
        test_writes("paused write");
        pause_on = 1'b0;
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/mem_ctrl_pkg.sv
hw/mem_arbiter_fsm.sv
hw/byte_counter.sv
hw/read_assembler.sv
hw/ram_bus_driver.sv
hw/mem_ctrl.sv
sim/mem_ctrl_chk.sv
sim/mem_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the memory controller testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module mem_ctrl_tb --Mdir obj_dir -o sim_mem_ctrl
./obj_dir/sim_mem_ctrl 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
